//--- all.f
+incdir+.
rf_pkg.sv
rf_wr_if.sv
rf_rd_if.sv
regfile.sv
operand_fetch.sv
dual_issue_rf_top.sv
tb_dual_issue_rf.sv

//--- tb_dual_issue_rf.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module tb_dual_issue_rf
	import rf_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;

	// cycle budget of the run holds one term per phase
	// reset, reset_clear, write_then_read, dual_write_collision,
	// same_cycle_bypass, immediate_format and back_to_back_issue
	localparam int BUDGET_CYCLES = RESET_CYCLES + 4 + 30 + 8 + 8 + 10 + 12;

	logic     clk;
	logic     aresetn;
	logic     issue_valid;
	inst_u    inst0;
	inst_u    inst1;
	logic     we1;
	rf_addr_t waddr1;
	rf_word_t wdata1;
	logic     we2;
	rf_addr_t waddr2;
	rf_word_t wdata2;
	logic     op_valid;
	rf_word_t op0_a;
	rf_word_t op0_b;
	rf_word_t op0_imm;
	rf_word_t op1_a;
	rf_word_t op1_b;
	rf_word_t op1_imm;
	logic     op0_is_imm;
	logic     op1_is_imm;

	// reference copy of the architectural registers where entry zero stays zero
	rf_word_t model_regs [0:`RF_NREGS-1];

	// operands expected one cycle after the last issue are indexed by slot
	rf_word_t exp_a [2];
	rf_word_t exp_b [2];
	rf_word_t exp_imm [2];
	logic     exp_is_imm [2];

	integer seed;
	int     error_count;
	int     test_count;
	int     failed_count;
	int     errors_at_start;
	logic   valid_seen_in_reset;

	dual_issue_rf_top i_dual_issue_rf_top (
		.clk         (clk),
		.aresetn     (aresetn),
		.issue_valid (issue_valid),
		.inst0       (inst0),
		.inst1       (inst1),
		.we1         (we1),
		.waddr1      (waddr1),
		.wdata1      (wdata1),
		.we2         (we2),
		.waddr2      (waddr2),
		.wdata2      (wdata2),
		.op_valid    (op_valid),
		.op0_a       (op0_a),
		.op0_b       (op0_b),
		.op0_imm     (op0_imm),
		.op1_a       (op1_a),
		.op1_b       (op1_b),
		.op1_imm     (op1_imm),
		.op0_is_imm  (op0_is_imm),
		.op1_is_imm  (op1_is_imm)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic check_word(input string name, input rf_word_t got, input rf_word_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Error %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			error_count++;
			$display("Error %s expected %h got %h", name, exp, got);
		end
	endtask

	// three-register instruction whose top ten bits carry the 3R tag
	function automatic inst_u make_3r(input rf_addr_t rk, input rf_addr_t rj,
			input rf_addr_t rdst);
		inst_u inst;
		inst = '0;
		inst.ri12.opc = `RF_OPC_3R;
		inst.r3.rk = rk;
		inst.r3.rj = rj;
		inst.r3.rd = rdst;
		return inst;
	endfunction

	// immediate instruction where the caller passes an opcode other than the 3R tag
	function automatic inst_u make_ri12(input logic [9:0] opc, input logic [11:0] si12,
			input rf_addr_t rj, input rf_addr_t rdst);
		inst_u inst;
		inst.ri12.opc = opc;
		inst.ri12.si12 = si12;
		inst.ri12.rj = rj;
		inst.ri12.rd = rdst;
		return inst;
	endfunction

	// random fields with the format forced one way or the other
	function automatic inst_u random_inst(input logic want_3r);
		inst_u inst;
		inst = $random(seed);
		if (want_3r) begin
			inst.ri12.opc = `RF_OPC_3R;
		end else if (inst.ri12.opc == `RF_OPC_3R) begin
			inst.ri12.opc = 10'h001;
		end
		return inst;
	endfunction

	function automatic rf_addr_t random_nonzero_addr();
		return rf_addr_t'(1 + ({$random(seed)} % (`RF_NREGS - 1)));
	endfunction

	// drives both write ports and applies the same writes to the model
	task automatic drive_writes(input logic e1, input rf_addr_t a1, input rf_word_t d1,
			input logic e2, input rf_addr_t a2, input rf_word_t d2);
		we1 = e1;
		waddr1 = a1;
		wdata1 = d1;
		we2 = e2;
		waddr2 = a2;
		wdata2 = d2;
		// register zero ignores writes and port 2 goes last so it wins a shared address
		if (e1 && a1 != '0) begin
			model_regs[a1] = d1;
		end
		if (e2 && a2 != '0) begin
			model_regs[a2] = d2;
		end
	endtask

	task automatic idle_writes();
		we1 = 1'b0;
		we2 = 1'b0;
	endtask

	// works out from the format rules what one slot must deliver
	task automatic expect_slot(input int slot, input inst_u inst);
		int       simm;
		rf_addr_t b_addr;
		exp_is_imm[slot] = (inst.ri12.opc != `RF_OPC_3R);
		if (exp_is_imm[slot]) begin
			// a store reads rd as its data, so the immediate format uses rd for b
			b_addr = inst.ri12.rd;
			simm = inst.ri12.si12;
			if (inst.ri12.si12[11]) begin
				simm = simm - 4096;
			end
			exp_imm[slot] = rf_word_t'(simm);
		end else begin
			b_addr = inst.r3.rk;
			exp_imm[slot] = '0;
		end
		// the model already holds this cycle's writes, which matches the bypass
		exp_a[slot] = model_regs[inst.r3.rj];
		exp_b[slot] = model_regs[b_addr];
	endtask

	task automatic issue_pair(input inst_u i0, input inst_u i1);
		issue_valid = 1'b1;
		inst0 = i0;
		inst1 = i1;
		expect_slot(0, i0);
		expect_slot(1, i1);
	endtask

	task automatic check_outputs();
		check_flag("op_valid", op_valid, 1'b1);
		check_word("op0_a", op0_a, exp_a[0]);
		check_word("op0_b", op0_b, exp_b[0]);
		check_word("op0_imm", op0_imm, exp_imm[0]);
		check_flag("op0_is_imm", op0_is_imm, exp_is_imm[0]);
		check_word("op1_a", op1_a, exp_a[1]);
		check_word("op1_b", op1_b, exp_b[1]);
		check_word("op1_imm", op1_imm, exp_imm[1]);
		check_flag("op1_is_imm", op1_is_imm, exp_is_imm[1]);
	endtask

	// called on a falling edge and returns on the falling edge after the capture
	task automatic issue_and_check(input inst_u i0, input inst_u i1);
		issue_pair(i0, i1);
		@(negedge clk);
		issue_valid = 1'b0;
		check_outputs();
	endtask

	task automatic begin_test();
		errors_at_start = error_count;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (error_count == errors_at_start) begin
			$display("test %s passed", name);
		end else begin
			failed_count++;
			$display("test %s failed with %0d errors", name, error_count - errors_at_start);
		end
	endtask

	task automatic reset_clear();
		begin_test();
		check_flag("op_valid_in_reset", valid_seen_in_reset, 1'b0);
		issue_and_check(make_3r(2, 1, 0), make_3r(4, 3, 0));
		finish_test("reset_clear");
	endtask

	task automatic write_then_read();
		begin_test();
		repeat (8) begin
			drive_writes(1'b1, random_nonzero_addr(), $random(seed),
				1'b1, random_nonzero_addr(), $random(seed));
			@(negedge clk);
			// no issue in the previous cycle means no valid operands now
			check_flag("op_valid_idle", op_valid, 1'b0);
		end
		idle_writes();
		// eight pairs sweep all 32 registers across the four read ports
		for (int k = 0; k < 8; k++) begin
			issue_and_check(make_3r(rf_addr_t'(4*k+1), rf_addr_t'(4*k), 0),
				make_3r(rf_addr_t'(4*k+3), rf_addr_t'(4*k+2), 0));
		end
		finish_test("write_then_read");
	endtask

	task automatic dual_write_collision();
		begin_test();
		drive_writes(1'b1, 7, 32'ha5a5_0001, 1'b1, 7, 32'h5a5a_0002);
		@(negedge clk);
		drive_writes(1'b1, 0, $random(seed), 1'b1, 0, $random(seed));
		@(negedge clk);
		idle_writes();
		issue_and_check(make_3r(0, 7, 0), make_3r(7, 0, 0));
		check_word("r7_after_collision", op0_a, 32'h5a5a_0002);
		check_word("r0_after_write", op1_a, 32'h0);
		finish_test("dual_write_collision");
	endtask

	task automatic same_cycle_bypass();
		rf_word_t late_data;
		begin_test();
		drive_writes(1'b1, 9, $random(seed), 1'b1, 10, $random(seed));
		issue_pair(make_3r(10, 9, 0), make_3r(9, 10, 0));
		@(negedge clk);
		check_outputs();
		// both ports hit the source register and the younger port must come through
		late_data = $random(seed);
		drive_writes(1'b1, 11, $random(seed), 1'b1, 11, late_data);
		issue_and_check(make_3r(11, 11, 0), make_ri12(10'h0c3, 12'h001, 11, 11));
		idle_writes();
		check_word("op0_a_bypass", op0_a, late_data);
		check_word("op1_b_bypass", op1_b, late_data);
		finish_test("same_cycle_bypass");
	endtask

	task automatic immediate_format();
		begin_test();
		issue_and_check(make_ri12(10'h0a8, 12'hf80, 3, 5), make_ri12(10'h28d, 12'h07f, 6, 7));
		check_word("op0_imm_negative", op0_imm, 32'hffff_ff80);
		check_word("op1_imm_positive", op1_imm, 32'h0000_007f);
		issue_and_check(make_ri12(10'h3ff, 12'h800, 12, 13), make_3r(15, 14, 16));
		issue_and_check(make_ri12(10'h001, 12'h7ff, 0, 7), make_ri12(10'h155, 12'hfff, 7, 0));
		finish_test("immediate_format");
	endtask

	task automatic back_to_back_issue();
		begin_test();
		for (int n = 0; n < 8; n++) begin
			// each falling edge checks the previous pair and issues the next one
			if (n > 0) begin
				check_outputs();
			end
			drive_writes(1'b1, rf_addr_t'($random(seed)), $random(seed),
				1'b1, rf_addr_t'($random(seed)), $random(seed));
			issue_pair(random_inst(n % 2 == 0), random_inst(n % 3 == 0));
			@(negedge clk);
		end
		idle_writes();
		issue_valid = 1'b0;
		check_outputs();
		finish_test("back_to_back_issue");
	endtask

	// the watchdog allows twice the summed cycle budget of reset and all tests
	initial begin
		#(2 * BUDGET_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", 2 * BUDGET_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		aresetn = 1'b0;
		// issue is held high through reset so that only the reset keeps op_valid low
		issue_valid = 1'b1;
		inst0 = '0;
		inst1 = '0;
		we1 = 1'b0;
		waddr1 = '0;
		wdata1 = '0;
		we2 = 1'b0;
		waddr2 = '0;
		wdata2 = '0;
		seed = 32'h14f2;
		error_count = 0;
		test_count = 0;
		failed_count = 0;
		errors_at_start = 0;
		valid_seen_in_reset = 1'b0;
		for (int i = 0; i < `RF_NREGS; i++) begin
			model_regs[i] = '0;
		end

		// op_valid must stay low at every edge while reset is held
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			if (op_valid !== 1'b0) begin
				valid_seen_in_reset = 1'b1;
			end
		end
		aresetn = 1'b1;
		issue_valid = 1'b0;

		reset_clear();
		write_then_read();
		dual_write_collision();
		same_cycle_bypass();
		immediate_format();
		back_to_back_issue();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			test_count, failed_count, error_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- dual_issue_rf_top.sv
`timescale 1ns/1ns

module dual_issue_rf_top
	import rf_pkg::*;
(
	input  logic     clk,
	input  logic     aresetn,
	input  logic     issue_valid,
	input  inst_u    inst0,
	input  inst_u    inst1,
	input  logic     we1,
	input  rf_addr_t waddr1,
	input  rf_word_t wdata1,
	input  logic     we2,
	input  rf_addr_t waddr2,
	input  rf_word_t wdata2,
	output logic     op_valid,
	output rf_word_t op0_a,
	output rf_word_t op0_b,
	output rf_word_t op0_imm,
	output rf_word_t op1_a,
	output rf_word_t op1_b,
	output rf_word_t op1_imm,
	output logic     op0_is_imm,
	output logic     op1_is_imm
);

	// writeback bus, fed straight from the top-level write ports
	rf_wr_if wr_bus ();

	// read bus between operand fetch and the register file
	rf_rd_if rd_bus ();

	assign wr_bus.we1    = we1;
	assign wr_bus.waddr1 = waddr1;
	assign wr_bus.wdata1 = wdata1;
	assign wr_bus.we2    = we2;
	assign wr_bus.waddr2 = waddr2;
	assign wr_bus.wdata2 = wdata2;

	// decode and operand registers, one cycle from issue to op_valid
	operand_fetch i_operand_fetch (
		.clk         (clk),
		.aresetn     (aresetn),
		.issue_valid (issue_valid),
		.inst0       (inst0),
		.inst1       (inst1),
		.rd          (rd_bus.req),
		.op_valid    (op_valid),
		.op0_a       (op0_a),
		.op0_b       (op0_b),
		.op0_imm     (op0_imm),
		.op1_a       (op1_a),
		.op1_b       (op1_b),
		.op1_imm     (op1_imm),
		.op0_is_imm  (op0_is_imm),
		.op1_is_imm  (op1_is_imm)
	);

	// storage with same-cycle forwarding of both write ports
	regfile i_regfile (
		.clk     (clk),
		.aresetn (aresetn),
		.wr      (wr_bus.dst),
		.rd      (rd_bus.rsp)
	);

endmodule

//--- operand_fetch.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module operand_fetch
	import rf_pkg::*;
(
	input  logic     clk,
	input  logic     aresetn,
	input  logic     issue_valid,
	input  inst_u    inst0,
	input  inst_u    inst1,
	rf_rd_if.req     rd,
	output logic     op_valid,
	output rf_word_t op0_a,
	output rf_word_t op0_b,
	output rf_word_t op0_imm,
	output rf_word_t op1_a,
	output rf_word_t op1_b,
	output rf_word_t op1_imm,
	output logic     op0_is_imm,
	output logic     op1_is_imm
);

	// an instruction is three-register when its top ten bits hold the 3R tag
	function automatic logic is_3r(input inst_u inst);
		return inst.ri12.opc == `RF_OPC_3R;
	endfunction

	// second source is rk for the 3R format
	// the immediate format reads rd instead, which a store uses as its data
	function automatic rf_addr_t src_b(input inst_u inst);
		rf_addr_t addr;
		if (is_3r(inst)) begin
			addr = inst.r3.rk;
		end else begin
			addr = inst.ri12.rd;
		end
		return addr;
	endfunction

	// si12 widened to a full word with its sign, zero for the 3R format
	function automatic rf_word_t sext_imm(input inst_u inst);
		rf_word_t imm;
		if (is_3r(inst)) begin
			imm = '0;
		end else begin
			imm = {{(`RF_XLEN-12){inst.ri12.si12[11]}}, inst.ri12.si12};
		end
		return imm;
	endfunction

	// decode of both slots, valid in the issue cycle
	logic     slot0_3r;
	logic     slot1_3r;
	rf_word_t slot0_imm;
	rf_word_t slot1_imm;

	assign slot0_3r  = is_3r(inst0);
	assign slot1_3r  = is_3r(inst1);
	assign slot0_imm = sext_imm(inst0);
	assign slot1_imm = sext_imm(inst1);

	// read addresses go out in the issue cycle itself
	// rj sits at the same place in both formats and needs no select
	assign rd.raddr1 = inst0.r3.rj;
	assign rd.raddr2 = src_b(inst0);
	assign rd.raddr3 = inst1.r3.rj;
	assign rd.raddr4 = src_b(inst1);

	// op_valid follows issue_valid by exactly one cycle
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= issue_valid;
		end
	end

	// operand stage, loaded once per issue and held until the next one
	// the read data already includes any write landing in the issue cycle
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			// slot 0 takes read ports 1 and 2
			op0_a      <= rd.rdata1;
			op0_b      <= rd.rdata2;
			op0_imm    <= slot0_imm;
			op0_is_imm <= !slot0_3r;
			// slot 1 takes read ports 3 and 4
			op1_a      <= rd.rdata3;
			op1_b      <= rd.rdata4;
			op1_imm    <= slot1_imm;
			op1_is_imm <= !slot1_3r;
		end
	end

endmodule

//--- regfile.sv
`timescale 1ns/1ns
`include "rf_defines.svh"

module regfile
	import rf_pkg::*;
(
	input logic  clk,
	input logic  aresetn,
	rf_wr_if.dst wr,
	rf_rd_if.rsp rd
);

	// storage for registers 1 and up
	// register zero is hardwired, so it has no entry here
	rf_word_t regs [1:`RF_NREGS-1];

	// shared read path of all four ports
	// the write data of this cycle is forwarded, so a reader never sees
	// the stale word one cycle before the write lands
	// port 2 is checked first because it holds the younger instruction
	function automatic rf_word_t read_port(input rf_addr_t addr);
		rf_word_t data;
		if (!aresetn) begin
			// nothing is valid while the core is held in reset
			data = '0;
		end else if (addr == '0) begin
			// register zero reads as zero whatever was written to it
			data = '0;
		end else if (wr.we2 && wr.waddr2 == addr) begin
			data = wr.wdata2;
		end else if (wr.we1 && wr.waddr1 == addr) begin
			data = wr.wdata1;
		end else begin
			data = regs[addr];
		end
		return data;
	endfunction

	// write side
	// both ports may write in the same cycle, each to any register
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			// all registers are cleared at each edge while reset is held
			for (int i = 1; i < `RF_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// writes that name register zero are simply dropped
			if (wr.we1 && wr.waddr1 != '0) begin
				regs[wr.waddr1] <= wr.wdata1;
			end
			// port 2 is applied after port 1, so on a shared address
			// the younger instruction's result is the one that remains
			if (wr.we2 && wr.waddr2 != '0) begin
				regs[wr.waddr2] <= wr.wdata2;
			end
		end
	end

	// read side
	// four independent ports, all combinational within the cycle

	// slot 0, first source
	always_comb begin
		rd.rdata1 = read_port(rd.raddr1);
	end

	// slot 0, second source
	always_comb begin
		rd.rdata2 = read_port(rd.raddr2);
	end

	// slot 1, first source
	always_comb begin
		rd.rdata3 = read_port(rd.raddr3);
	end

	// slot 1, second source
	always_comb begin
		rd.rdata4 = read_port(rd.raddr4);
	end

endmodule

//--- rf_rd_if.sv
`timescale 1ns/1ns

interface rf_rd_if
	import rf_pkg::*;
();
	// ports 1 and 2 serve instruction slot 0
	rf_addr_t raddr1;
	rf_addr_t raddr2;
	rf_word_t rdata1;
	rf_word_t rdata2;

	// ports 3 and 4 serve instruction slot 1
	rf_addr_t raddr3;
	rf_addr_t raddr4;
	rf_word_t rdata3;
	rf_word_t rdata4;

	// operand fetch drives the addresses and takes the data back
	modport req (
		output raddr1, raddr2, raddr3, raddr4,
		input  rdata1, rdata2, rdata3, rdata4
	);

	// register file answers in the same cycle, with no register in the path
	modport rsp (
		input  raddr1, raddr2, raddr3, raddr4,
		output rdata1, rdata2, rdata3, rdata4
	);

endinterface

//--- rf_wr_if.sv
`timescale 1ns/1ns

interface rf_wr_if
	import rf_pkg::*;
();
	// write port 1 carries the older instruction of the pair
	logic     we1;
	rf_addr_t waddr1;
	rf_word_t wdata1;

	// write port 2 carries the younger instruction and wins on a shared address
	logic     we2;
	rf_addr_t waddr2;
	rf_word_t wdata2;

	// writeback side that launches the writes
	modport src (output we1, waddr1, wdata1, we2, waddr2, wdata2);

	// register file side, enables are sampled at the rising clock edge
	modport dst (input we1, waddr1, wdata1, we2, waddr2, wdata2);

endinterface

//--- rf_pkg.sv
`include "rf_defines.svh"

package rf_pkg;

	// one data word as held in the register file and carried on the operand buses
	typedef logic [`RF_XLEN-1:0] rf_word_t;

	// register number as found in the instruction fields
	typedef logic [`RF_AW-1:0] rf_addr_t;

	// one instruction word seen through its two encodings
	// rd sits in bits 4..0 and rj in bits 9..5 in both views,
	// so the destination and the first source never depend on the format
	typedef union packed {
		// three-register view, opcode in bits 31..15 and rk in bits 14..10
		struct packed {
			logic [16:0] opc;
			rf_addr_t    rk;
			rf_addr_t    rj;
			rf_addr_t    rd;
		} r3;
		// register plus immediate view, opcode in bits 31..22
		// the signed immediate occupies bits 21..10 and overlaps rk
		struct packed {
			logic [9:0]  opc;
			logic [11:0] si12;
			rf_addr_t    rj;
			rf_addr_t    rd;
		} ri12;
	} inst_u;

endpackage

//--- rf_defines.svh
`ifndef RF_DEFINES_SVH
`define RF_DEFINES_SVH

// width of one data word and of every register
`define RF_XLEN 32

// number of architectural general registers, register zero included
`define RF_NREGS 32

// bits needed to name one of the general registers
`define RF_AW 5

// top ten instruction bits of the three-register format
// any other value is treated as the register plus 12-bit immediate format
`define RF_OPC_3R 10'd0

`endif
